//--- logic/fpAdder_params.svh
// Single-precision format widths and constants, included by the adder RTL that needs them.
`ifndef FPADDER_PARAMS_SVH
`define FPADDER_PARAMS_SVH

`define FP_EXP_BITS   8
`define FP_MAN_BITS   23
`define FP_ALIGN_BITS 32
`define FP_EXP_MAX    255
`define FP_QNAN       32'h7FC00000

`endif

//--- logic/fpPkg.sv
// Shared operand word and class-flag types for the floating-point adder and its testbench.
`default_nettype none

`include "fpAdder_params.svh"

package fpPkg;

    // One IEEE-754 single word, seen either raw or split into its fields.
    typedef union packed
    {
        logic [31:0] bits;
        struct packed
        {
            logic                      sign;
            logic [`FP_EXP_BITS-1:0]   exponent;
            logic [`FP_MAN_BITS-1:0]   mantissa;
        } fields;
    } fpWord;

    typedef struct packed
    {
        logic nan;
        logic inf;
        logic zero;
        logic sub;    // Subnormal, hidden bit is zero.
    } fpClass;

endpackage

`default_nettype wire

//--- logic/fpBus.sv
// Stage-to-stage bundle carrying unpacked operands, class flags and alignment results.
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

interface fpBus;

    logic                        signA, signB;
    logic [`FP_EXP_BITS-1:0]     exponentA, exponentB;
    logic [`FP_MAN_BITS-1:0]     mantissaA, mantissaB;
    fpPkg::fpClass               classA, classB;
    logic                        inValid;

    logic                        Aex, Bex;       // Which operand has the larger exponent.
    logic [`FP_EXP_BITS-1:0]     exponentOut;
    logic [`FP_ALIGN_BITS-1:0]   alignedMantissaA, alignedMantissaB;
    logic                        sticky, shiftOverflow, bypassALU;

    modport unpack (output signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                    classA, classB, inValid);

    modport align (input exponentA, exponentB, mantissaA, mantissaB, classA, classB,
                   output Aex, Bex, exponentOut, alignedMantissaA, alignedMantissaB,
                   sticky, shiftOverflow, bypassALU);

    modport round (input signA, signB, exponentA, exponentB, mantissaA, mantissaB,
                   classA, classB, inValid, Aex, Bex, exponentOut, alignedMantissaA,
                   alignedMantissaB, sticky, shiftOverflow, bypassALU);

endinterface

`default_nettype wire

//--- logic/fpOperandLatch.sv
// Input side of the adder; takes operands over a four-phase handshake and unpacks them.
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpOperandLatch (
    input  logic          clk,
    input  logic          rstN,
    input  fpPkg::fpWord  opA,
    input  fpPkg::fpWord  opB,
    input  logic          subtract,
    input  logic          inReq,
    output logic          inAck,
    input  logic          taken,
    fpBus.unpack          bus
);

    fpPkg::fpWord opAReg, opBReg, opBEff;
    logic         full;
    logic         load;

    function automatic fpPkg::fpClass classify(input fpPkg::fpWord w);
        fpPkg::fpClass c;
        logic          expOnes;
        logic          expZero;
        logic          manZero;
        expOnes = (w.fields.exponent == `FP_EXP_MAX);
        expZero = (w.fields.exponent == 0);
        manZero = (w.fields.mantissa == 0);
        c.nan  = expOnes & ~manZero;
        c.inf  = expOnes & manZero;
        c.zero = expZero & manZero;
        c.sub  = expZero & ~manZero;
        return c;
    endfunction

    // Subtraction is addition of B with its sign flipped.
    assign opBEff.bits = {opB.fields.sign ^ subtract, opB.bits[30:0]};

    assign load = inReq & ~full & ~inAck;    // Previous handshake must be closed.

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            full  <= 1'b0;
            inAck <= 1'b0;
        end
        else
        begin
            if (load)
                full <= 1'b1;
            else if (taken)
                full <= 1'b0;

            if (load)
                inAck <= 1'b1;
            else if (inAck && !inReq)
                inAck <= 1'b0;    // Fourth phase.
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            opAReg <= opA;
            opBReg <= opBEff;
        end
    end

    assign bus.signA     = opAReg.fields.sign;
    assign bus.signB     = opBReg.fields.sign;
    assign bus.exponentA = opAReg.fields.exponent;
    assign bus.exponentB = opBReg.fields.exponent;
    assign bus.mantissaA = opAReg.fields.mantissa;
    assign bus.mantissaB = opBReg.fields.mantissa;
    assign bus.classA    = classify(opAReg);
    assign bus.classB    = classify(opBReg);
    assign bus.inValid   = full;

endmodule

`default_nettype wire

//--- logic/alignment.sv
// Exponent compare and mantissa alignment stage, feeding the add and round logic.
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module alignment (fpBus.align bus);

    logic [`FP_EXP_BITS-1:0]   effExpA, effExpB;
    logic [`FP_EXP_BITS-1:0]   exponentDifferential;
    logic [`FP_ALIGN_BITS-1:0] fullA, fullB;
    logic [`FP_ALIGN_BITS-1:0] smallFull, shifted, lostMask;
    logic                      aGreater, bGreater;

    // A subnormal sits at the same scale as exponent 1.
    assign effExpA = bus.classA.sub ? `FP_EXP_BITS'(1) : bus.exponentA;
    assign effExpB = bus.classB.sub ? `FP_EXP_BITS'(1) : bus.exponentB;

    // Hidden bit, fraction, then eight guard bits.
    assign fullA = {~bus.classA.sub, bus.mantissaA, 8'b0};
    assign fullB = {~bus.classB.sub, bus.mantissaB, 8'b0};

    assign aGreater = (effExpA > effExpB);
    assign bGreater = (effExpA < effExpB);
    assign bus.Aex  = aGreater;
    assign bus.Bex  = bGreater;

    assign bus.bypassALU = bus.classA.nan | bus.classB.nan | bus.classA.inf |
                           bus.classB.inf | bus.classA.zero | bus.classB.zero;

    always_comb
    begin
        if (aGreater)
        begin
            bus.exponentOut      = effExpA;
            exponentDifferential = effExpA - effExpB;
            smallFull            = fullB;
        end
        else
        begin
            // Equal exponents land here with a zero shift.
            bus.exponentOut      = effExpB;
            exponentDifferential = effExpB - effExpA;
            smallFull            = fullA;
        end
    end

    assign shifted = smallFull >> exponentDifferential;

    assign bus.alignedMantissaA = aGreater ? fullA : shifted;
    assign bus.alignedMantissaB = aGreater ? shifted : fullB;

    // Mask of the bits that drop off the bottom of the aligned field.
    assign lostMask = ~({`FP_ALIGN_BITS{1'b1}} << exponentDifferential);

    assign bus.sticky = |(smallFull & lostMask);

    // The whole smaller significand has left the field.
    assign bus.shiftOverflow = (exponentDifferential >= `FP_ALIGN_BITS) & (|smallFull);

endmodule

`default_nettype wire

//--- logic/fpAddRound.sv
// Mantissa add or subtract, normalization, round to nearest even and special-operand results.
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpAddRound (
    fpBus.round           bus,
    output fpPkg::fpWord  sum
);

    logic                aBig;
    logic                bigSign;
    logic                effSub;
    logic [`FP_ALIGN_BITS-1:0] bigMan, smallMan;
    logic [33:0]         bigExt, smallExt, raw;
    logic [5:0]          lz;
    logic [32:0]         norm;
    logic                lostBit;
    logic                roundUp;
    logic [24:0]         rounded;
    logic signed [9:0]   expNorm, expFinal;
    fpPkg::fpWord        wordA, wordB, bigWord, normWord, special;

    function automatic logic [5:0] leadingZeros(input logic [32:0] v);
        logic [5:0] n;
        logic       found;
        n     = 6'd0;
        found = 1'b0;
        for (int i = 32; i >= 0; i--)
        begin
            if (!found)
            begin
                if (v[i])
                    found = 1'b1;
                else
                    n = n + 6'd1;
            end
        end
        return n;
    endfunction

    assign wordA.bits = {bus.signA, bus.exponentA, bus.mantissaA};
    assign wordB.bits = {bus.signB, bus.exponentB, bus.mantissaB};

    assign aBig    = bus.Aex | (~bus.Bex & (bus.alignedMantissaA >= bus.alignedMantissaB));
    assign bigSign = aBig ? bus.signA : bus.signB;
    assign bigWord = aBig ? wordA : wordB;
    assign bigMan   = aBig ? bus.alignedMantissaA : bus.alignedMantissaB;
    assign smallMan = aBig ? bus.alignedMantissaB : bus.alignedMantissaA;
    assign effSub   = bus.signA ^ bus.signB;

    // Sticky rides below the guard bits of the smaller operand.
    assign bigExt   = {1'b0, bigMan, 1'b0};
    assign smallExt = {1'b0, smallMan, bus.sticky};
    assign raw      = effSub ? bigExt - smallExt : bigExt + smallExt;
    assign lz       = leadingZeros(raw[32:0]);

    always_comb
    begin
        if (raw[33])
        begin
            norm    = raw[33:1];    // Carry out, one right shift.
            lostBit = raw[0];
            expNorm = $signed({2'b00, bus.exponentOut}) + 10'sd1;
        end
        else
        begin
            norm    = raw[32:0] << lz;
            lostBit = 1'b0;
            expNorm = $signed({2'b00, bus.exponentOut}) - $signed({4'b0000, lz});
        end

        roundUp  = norm[8] & (norm[9] | (|norm[7:0]) | lostBit);
        rounded  = {1'b0, norm[32:9]} + {24'b0, roundUp};
        expFinal = expNorm + $signed({9'b0, rounded[24]});

        normWord.fields.sign     = bigSign;
        normWord.fields.exponent = expFinal[7:0];
        // A rounding carry leaves the fraction all zeros.
        normWord.fields.mantissa = rounded[22:0];
        if (expFinal >= 10'sd255)
            normWord.bits = {bigSign, 8'hFF, 23'b0};
        else if (expFinal <= 10'sd0)
            normWord.bits = {bigSign, 31'b0};    // Subnormal results flush to zero.
    end

    always_comb
    begin
        if (bus.classA.nan || bus.classB.nan || (bus.classA.inf && bus.classB.inf && effSub))
            special.bits = `FP_QNAN;
        else if (bus.classA.inf)
            special = wordA;
        else if (bus.classB.inf)
            special = wordB;
        else if (bus.classA.zero && bus.classB.zero)
            special.bits = {bus.signA & bus.signB, 31'b0};
        else if (bus.classA.zero)
            special.bits = bus.classB.sub ? {bus.signB, 31'b0} : wordB.bits;
        else
            special.bits = bus.classA.sub ? {bus.signA, 31'b0} : wordA.bits;
    end

    always_comb
    begin
        if (bus.bypassALU)
            sum = special;
        else if (bus.shiftOverflow)
            sum = bigWord;    // Smaller operand is far below half an ulp.
        else if (raw == 34'b0)
            sum.bits = 32'b0;    // Exact cancellation gives +0.
        else
            sum = normWord;
    end

endmodule

`default_nettype wire

//--- logic/fpResultLatch.sv
// Output side of the adder; registers a result and offers it over a four-phase handshake.
`timescale 1ns/1ps
`default_nettype none

module fpResultLatch (
    input  logic          clk,
    input  logic          rstN,
    input  logic          inValid,
    input  fpPkg::fpWord  sum,
    output logic          taken,
    output fpPkg::fpWord  result,
    output logic          outReq,
    input  logic          outAck
);

    logic full;
    logic load;

    assign load = inValid & ~full;

    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            full   <= 1'b0;
            outReq <= 1'b0;
            taken  <= 1'b0;
        end
        else
        begin
            taken <= load;    // Frees the operand latch one edge later.
            if (load)
            begin
                full   <= 1'b1;
                outReq <= 1'b1;
            end
            else if (outReq && outAck)
                outReq <= 1'b0;
            else if (full && !outReq && !outAck)
                full <= 1'b0;    // Handshake closed.
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
            result <= sum;
    end

endmodule

`default_nettype wire

//--- logic/fpAdder.sv
// Top level of the single-precision add/subtract unit with req/ack handshakes on both sides.
`timescale 1ns/1ps
`default_nettype none

module fpAdder (
    input  logic          clk,
    input  logic          rstN,
    input  fpPkg::fpWord  opA,
    input  fpPkg::fpWord  opB,
    input  logic          subtract,
    input  logic          inReq,
    output logic          inAck,
    output fpPkg::fpWord  result,
    output logic          outReq,
    input  logic          outAck
);

    fpPkg::fpWord sum;
    logic         taken;

    fpBus bus ();

    fpOperandLatch inLatch (
        .clk(clk), .rstN(rstN), .opA(opA), .opB(opB), .subtract(subtract),
        .inReq(inReq), .inAck(inAck), .taken(taken), .bus(bus)
    );

    alignment alignStage (.bus(bus));

    fpAddRound addStage (.bus(bus), .sum(sum));

    // Both stages above are combinational between the two latches.
    fpResultLatch outLatch (
        .clk(clk), .rstN(rstN), .inValid(bus.inValid), .sum(sum), .taken(taken),
        .result(result), .outReq(outReq), .outAck(outAck)
    );

endmodule

`default_nettype wire

//--- sim/clockGen.sv
// Testbench clock and reset source; 8 ns clock period with reset held low for five cycles.
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial
    begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);    // Release away from the active edge.
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- sim/fpAdderTb.sv
// Table-driven testbench for the adder; drives both handshakes and checks results in order.
`timescale 1ns/1ps
`default_nettype none

`include "fpAdder_params.svh"

module fpAdderTb;

    localparam int MaxEntries = 40;

    logic         clk;
    logic         rstN;
    fpPkg::fpWord opA;
    fpPkg::fpWord opB;
    fpPkg::fpWord result;
    logic         subtract;
    logic         inReq;
    logic         inAck;
    logic         outReq;
    logic         outAck;

    fpPkg::fpWord tabA [MaxEntries];
    fpPkg::fpWord tabB [MaxEntries];
    logic         tabSub [MaxEntries];
    fpPkg::fpWord tabExp [MaxEntries];
    int           tabDelay [MaxEntries];    // Cycles the consumer waits before acking.

    int           numEntries = 0;
    int           valueErrors = 0;
    int           protocolErrors = 0;
    int           cycles = 0;
    int           cycleLimit = 0;
    int           sentIdx = 0;
    int           gotIdx = 0;
    int           extraOffers = 0;
    logic         tableReady = 1'b0;

    logic         prevInReq = 1'b0;
    logic         prevInAck = 1'b0;
    logic         prevOutReq = 1'b0;
    logic         prevOutAck = 1'b0;
    fpPkg::fpWord prevResult;

    clockGen clocks (.clk(clk), .rstN(rstN));

    fpAdder UUT (
        .clk(clk), .rstN(rstN), .opA(opA), .opB(opB), .subtract(subtract),
        .inReq(inReq), .inAck(inAck), .result(result), .outReq(outReq), .outAck(outAck)
    );

    task automatic addEntry(input logic [31:0] a, input logic [31:0] b, input logic sub,
                            input logic [31:0] expected, input int delay);
        tabA[numEntries].bits   = a;
        tabB[numEntries].bits   = b;
        tabSub[numEntries]      = sub;
        tabExp[numEntries].bits = expected;
        tabDelay[numEntries]    = delay;
        numEntries++;
    endtask

    task automatic checkWord(input string name, input fpPkg::fpWord got,
                             input fpPkg::fpWord expected);
        if (got.bits !== expected.bits)
        begin
            valueErrors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got.bits,
                     expected.bits);
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            valueErrors++;
            $display("ERROR at %0t: %s got %b expected %b", $time, name, got, expected);
        end
    endtask

    task automatic reportViolation(input string what);
        protocolErrors++;
        $display("Handshake violation at %0t: %s", $time, what);
    endtask

    task automatic loadTable();
        addEntry(32'h3F800000, 32'h40000000, 1'b0, 32'h40400000, 0);    // 1 + 2.
        addEntry(32'h3F800000, 32'h3F400000, 1'b1, 32'h3E800000, 0);    // 1 - 0.75.
        addEntry(32'h3F800000, 32'hBF400000, 1'b0, 32'h3E800000, 3);    // Same as the row above.
        addEntry(32'h3FC00000, 32'h40200000, 1'b0, 32'h40800000, 0);
        addEntry(32'h3F800000, 32'h3E800000, 1'b0, 32'h3FA00000, 6);
        addEntry(32'h3F800000, 32'h40000000, 1'b1, 32'hBF800000, 0);
        addEntry(32'h3F800000, 32'h3F7FFFFF, 1'b1, 32'h33800000, 2);
        // Half an ulp ties to even, above half rounds up.
        addEntry(32'h3F800000, 32'h33800000, 1'b0, 32'h3F800000, 0);
        addEntry(32'h3F800000, 32'h33C00000, 1'b0, 32'h3F800001, 0);
        addEntry(32'h3F800001, 32'h33800000, 1'b0, 32'h3F800002, 4);
        addEntry(32'h3FFFFFFF, 32'h33800000, 1'b0, 32'h40000000, 0);
        addEntry(32'h3F800000, 32'h2B800000, 1'b0, 32'h3F800000, 0);
        addEntry(32'h7FC00000, 32'h3F800000, 1'b0, `FP_QNAN, 5);
        addEntry(32'h3F800000, 32'h7F800001, 1'b0, `FP_QNAN, 0);
        addEntry(32'h7F800000, 32'h3F800000, 1'b0, 32'h7F800000, 0);
        addEntry(32'hFF800000, 32'h3F800000, 1'b0, 32'hFF800000, 1);
        addEntry(32'h7F800000, 32'h7F800000, 1'b1, `FP_QNAN, 0);
        addEntry(32'h40400000, 32'h00000000, 1'b0, 32'h40400000, 0);
        addEntry(32'h80000000, 32'hC0400000, 1'b0, 32'hC0400000, 3);
        addEntry(32'h80000000, 32'h80000000, 1'b0, 32'h80000000, 0);
        addEntry(32'h00000000, 32'h80000000, 1'b0, 32'h00000000, 0);
        addEntry(32'h80000000, 32'h00000000, 1'b1, 32'h80000000, 6);
        addEntry(32'h7F7FFFFF, 32'h7F7FFFFF, 1'b0, 32'h7F800000, 0);
        addEntry(32'h40400000, 32'h40400000, 1'b1, 32'h00000000, 0);
        addEntry(32'h40400000, 32'hC0400000, 1'b0, 32'h00000000, 2);
        addEntry(32'h00400000, 32'h00800000, 1'b0, 32'h00C00000, 0);    // Subnormal input.
        addEntry(32'h00C00000, 32'h00800000, 1'b1, 32'h00000000, 0);
        addEntry(32'h80C00000, 32'h00800000, 1'b0, 32'h80000000, 5);
        addEntry(32'h40A00000, 32'h3F800000, 1'b1, 32'h40800000, 0);
        addEntry(32'h40A00000, 32'hBF800000, 1'b0, 32'h40800000, 0);
    endtask

    task automatic driveInputs();
        for (int i = 0; i < numEntries; i++)
        begin
            sentIdx  = i;
            opA      = tabA[i];
            opB      = tabB[i];
            subtract = tabSub[i];
            inReq    = 1'b1;
            do @(negedge clk); while (!inAck);
            inReq = 1'b0;
            do @(negedge clk); while (inAck);
        end
        sentIdx = numEntries;
    endtask

    task automatic consumeResults();
        for (int i = 0; i < numEntries; i++)
        begin
            while (!outReq)
                @(negedge clk);
            checkWord($sformatf("result[%0d]", i), result, tabExp[i]);
            repeat (tabDelay[i]) @(negedge clk);
            outAck = 1'b1;
            do @(negedge clk); while (outReq);
            outAck = 1'b0;
            gotIdx = i + 1;
        end
    endtask

    // Flop outputs read here still hold the values from before this edge.
    always @(posedge clk)
    begin
        if (rstN)
        begin
            if (!prevInAck && inAck && !prevInReq)
                reportViolation("inAck rose while inReq was low");
            if (prevInAck && !inAck && prevInReq)
                reportViolation("inAck dropped while inReq was still high");
            if (!prevOutReq && outReq && prevOutAck)
                reportViolation("outReq rose while outAck was still high");
            if (prevOutReq && !outReq && !prevOutAck)
                reportViolation("outReq dropped before outAck was seen");
            if (prevOutReq && outReq && (result.bits !== prevResult.bits))
                reportViolation("result changed while outReq was high");
        end
        prevInReq  = inReq;
        prevInAck  = inAck;
        prevOutReq = outReq;
        prevOutAck = outAck;
        prevResult = result;
    end

    initial
    begin
        opA.bits = 32'b0;
        opB.bits = 32'b0;
        subtract = 1'b0;
        inReq    = 1'b0;
        outAck   = 1'b0;
        loadTable();
        cycleLimit = (numEntries + 1) * 20;
        tableReady = 1'b1;

        wait (rstN === 1'b1);
        @(negedge clk);
        checkBit("inAck", inAck, 1'b0);
        checkBit("outReq", outReq, 1'b0);

        fork
            driveInputs();
            consumeResults();
        join

        // Nothing may be offered once every entry has come back.
        repeat (10)
        begin
            @(negedge clk);
            if (outReq)
                extraOffers++;
        end
        if (extraOffers != 0)
            reportViolation("a result was offered after the last table entry");

        $display("%0d value errors, %0d protocol errors", valueErrors, protocolErrors);
        if (valueErrors == 0 && protocolErrors == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

    initial
    begin
        wait (tableReady);
        while (cycles < cycleLimit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the input handshake reached entry %0d", cycles,
                 sentIdx);
        $display("and the output handshake reached entry %0d without finishing", gotIdx);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+logic
logic/fpPkg.sv
logic/fpBus.sv
logic/fpOperandLatch.sv
logic/alignment.sv
logic/fpAddRound.sv
logic/fpResultLatch.sv
logic/fpAdder.sv
sim/clockGen.sv
sim/fpAdderTb.sv

//--- Makefile
# Verilator build and run of the floating-point adder testbench.
TOP       ?= fpAdderTb
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --timescale 1ns/1ps
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Override TOP, VERILATOR, FLAGS or OBJDIR on the command line."

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f build.f
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "test passed"

clean:
	rm -rf $(OBJDIR)
